// ==== design/mem_ctrl_settings.svh ====
`ifndef MEM_CTRL_SETTINGS_SVH
`define MEM_CTRL_SETTINGS_SVH

// host entry and sram word widths
`define DATA_W 64
`define WORD_W 32
`define ADDR_W 10

// each entry takes two words, so a region spans 336 words
`define REGION_ENTRIES 168

// word bases of the three regions
`define WEIGHT_BASE 0
`define INPUT_BASE 336
`define OUTPUT_BASE 672

`endif

// ==== design/mem_ctrl_pkg.sv ====
`include "mem_ctrl_settings.svh"

package mem_ctrl_pkg;

    // two-bit status reported by the sram
    typedef enum logic [1:0] {
        SRAM_IDLE = 2'd0,
        SRAM_BUSY = 2'd1,
        SRAM_DONE = 2'd2,
        SRAM_ERR  = 2'd3
    } sram_state_t;

    // also used as index into the per-region arrays
    typedef enum logic [1:0] {
        REG_WEIGHT = 2'd0,
        REG_INPUT  = 2'd1,
        REG_OUTPUT = 2'd2
    } region_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_WAIT_LO,
        SEQ_ACC_LO,
        SEQ_WAIT_HI,
        SEQ_ACC_HI,
        SEQ_FINISH,
        SEQ_ERR_1,
        SEQ_ERR_2
    } seq_state_t;

    typedef enum logic [2:0] {
        OP_WR_WEIGHT,
        OP_WR_INPUT,
        OP_WR_OUTPUT,
        OP_LD_WEIGHT,
        OP_LD_INPUT,
        OP_RD_OUTPUT
    } op_t;

    typedef struct packed {
        logic write_weight;
        logic write_input;
        logic load_weight;
        logic start_inference;
        logic output_read;
    } host_cmd_t;

    typedef struct packed {
        logic design_busy;
        logic busy_err;
        logic occu_err_w;
        logic occu_err_i;
        logic occu_err_o;
    } ctrl_status_t;

    typedef struct packed {
        logic push;
        logic pop;
    } region_step_t;

    typedef struct packed {
        logic full;
        logic empty;
    } region_flags_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] wr_addr;
        logic [`ADDR_W-1:0] rd_addr;
    } region_addr_t;

    typedef struct packed {
        logic    read_en;
        logic    write_en;
        region_t region;
        logic    hi;
        logic    capture;
    } sram_access_t;

    typedef struct packed {
        logic               read_en;
        logic               write_en;
        logic [`ADDR_W-1:0] addr;
        logic [`WORD_W-1:0] write_data;
    } sram_req_t;

endpackage

// ==== design/cmd_sequencer.sv ====
module cmd_sequencer (
    input  logic                              clk,
    input  logic                              n_rst,
    input  mem_ctrl_pkg::host_cmd_t           cmd_i,
    input  logic                              activations_valid_i,
    input  logic                              array_busy_i,
    input  mem_ctrl_pkg::sram_state_t         sram_state_i,
    input  mem_ctrl_pkg::region_flags_t [2:0] flags_i,
    output mem_ctrl_pkg::region_step_t  [2:0] step_o,
    output mem_ctrl_pkg::sram_access_t        access_o,
    output mem_ctrl_pkg::ctrl_status_t        status_o,
    output logic                              load_o,
    output logic                              array_start_o
);

    mem_ctrl_pkg::seq_state_t state;
    mem_ctrl_pkg::seq_state_t state_n;
    mem_ctrl_pkg::op_t        op;
    mem_ctrl_pkg::op_t        op_n;
    mem_ctrl_pkg::region_t    region;
    logic                     is_write;
    logic [5:0]               strobes;
    logic [5:0]               own_strobe;
    logic                     any_cmd;
    logic                     foreign;
    logic                     occu_hit;
    logic                     sram_ready;
    logic                     busy;
    logic                     in_acc;
    logic                     in_err;
    logic                     err_busy;

    // bit order matches the idle priority, msb first
    assign strobes = {cmd_i.load_weight, cmd_i.write_weight, cmd_i.start_inference,
                      cmd_i.write_input, activations_valid_i, cmd_i.output_read};
    assign any_cmd = |strobes;

    always_comb begin
        if (cmd_i.load_weight)
            op_n = mem_ctrl_pkg::OP_LD_WEIGHT;
        else if (cmd_i.write_weight)
            op_n = mem_ctrl_pkg::OP_WR_WEIGHT;
        else if (cmd_i.start_inference)
            op_n = mem_ctrl_pkg::OP_LD_INPUT;
        else if (cmd_i.write_input)
            op_n = mem_ctrl_pkg::OP_WR_INPUT;
        else if (activations_valid_i)
            op_n = mem_ctrl_pkg::OP_WR_OUTPUT;
        else
            op_n = mem_ctrl_pkg::OP_RD_OUTPUT;
    end

    // region, direction and own strobe of the latched op
    always_comb begin
        region     = mem_ctrl_pkg::REG_WEIGHT;
        is_write   = 1'b0;
        own_strobe = '0;
        case (op)
            mem_ctrl_pkg::OP_WR_WEIGHT: begin
                is_write   = 1'b1;
                own_strobe = 6'b010000;
            end
            mem_ctrl_pkg::OP_WR_INPUT: begin
                region     = mem_ctrl_pkg::REG_INPUT;
                is_write   = 1'b1;
                own_strobe = 6'b000100;
            end
            mem_ctrl_pkg::OP_WR_OUTPUT: begin
                region     = mem_ctrl_pkg::REG_OUTPUT;
                is_write   = 1'b1;
                own_strobe = 6'b000010;
            end
            mem_ctrl_pkg::OP_LD_WEIGHT: begin
                own_strobe = 6'b100000;
            end
            mem_ctrl_pkg::OP_LD_INPUT: begin
                region     = mem_ctrl_pkg::REG_INPUT;
                own_strobe = 6'b001000;
            end
            mem_ctrl_pkg::OP_RD_OUTPUT: begin
                region     = mem_ctrl_pkg::REG_OUTPUT;
                own_strobe = 6'b000001;
            end
            default: ;
        endcase
    end

    assign foreign  = |(strobes & ~own_strobe);
    assign occu_hit = is_write ? flags_i[region].full : flags_i[region].empty;
    // weight loads also wait for the array
    assign sram_ready = (sram_state_i == mem_ctrl_pkg::SRAM_IDLE) &&
                        !(op == mem_ctrl_pkg::OP_LD_WEIGHT && array_busy_i);

    assign busy   = (state != mem_ctrl_pkg::SEQ_IDLE) && !in_err;
    assign in_acc = (state == mem_ctrl_pkg::SEQ_ACC_LO) || (state == mem_ctrl_pkg::SEQ_ACC_HI);
    assign in_err = (state == mem_ctrl_pkg::SEQ_ERR_1) || (state == mem_ctrl_pkg::SEQ_ERR_2);

    always_comb begin
        state_n = state;
        if (busy && foreign) begin
            state_n = mem_ctrl_pkg::SEQ_ERR_1;
        end else begin
            case (state)
                mem_ctrl_pkg::SEQ_IDLE: begin
                    if (any_cmd)
                        state_n = mem_ctrl_pkg::SEQ_WAIT_LO;
                end
                mem_ctrl_pkg::SEQ_WAIT_LO: begin
                    if (occu_hit)
                        state_n = mem_ctrl_pkg::SEQ_ERR_1;
                    else if (sram_ready)
                        state_n = mem_ctrl_pkg::SEQ_ACC_LO;
                end
                mem_ctrl_pkg::SEQ_ACC_LO: begin
                    if (sram_state_i == mem_ctrl_pkg::SRAM_DONE)
                        state_n = mem_ctrl_pkg::SEQ_WAIT_HI;
                    else if (sram_state_i == mem_ctrl_pkg::SRAM_ERR)
                        state_n = mem_ctrl_pkg::SEQ_IDLE;
                end
                mem_ctrl_pkg::SEQ_WAIT_HI: begin
                    if (sram_ready)
                        state_n = mem_ctrl_pkg::SEQ_ACC_HI;
                end
                mem_ctrl_pkg::SEQ_ACC_HI: begin
                    if (sram_state_i == mem_ctrl_pkg::SRAM_DONE)
                        state_n = mem_ctrl_pkg::SEQ_FINISH;
                    else if (sram_state_i == mem_ctrl_pkg::SRAM_ERR)
                        state_n = mem_ctrl_pkg::SEQ_IDLE;
                end
                mem_ctrl_pkg::SEQ_ERR_1: state_n = mem_ctrl_pkg::SEQ_ERR_2;
                default: state_n = mem_ctrl_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= mem_ctrl_pkg::SEQ_IDLE;
            op       <= mem_ctrl_pkg::OP_WR_WEIGHT;
            err_busy <= 1'b0;
        end else begin
            state <= state_n;
            if (state == mem_ctrl_pkg::SEQ_IDLE && any_cmd)
                op <= op_n;
            // busy wins over occupancy on the way into the error pair
            if (state_n == mem_ctrl_pkg::SEQ_ERR_1)
                err_busy <= foreign;
        end
    end

    assign access_o.read_en  = in_acc && !is_write;
    assign access_o.write_en = in_acc && is_write;
    assign access_o.region   = region;
    assign access_o.hi       = (state == mem_ctrl_pkg::SEQ_WAIT_HI) ||
                               (state == mem_ctrl_pkg::SEQ_ACC_HI);
    assign access_o.capture  = in_acc && !is_write &&
                               (sram_state_i == mem_ctrl_pkg::SRAM_DONE);

    // pointers move only once the whole entry is done
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            step_o[r].push = (state == mem_ctrl_pkg::SEQ_FINISH) && is_write &&
                             (region == mem_ctrl_pkg::region_t'(r));
            step_o[r].pop  = (state == mem_ctrl_pkg::SEQ_FINISH) && !is_write &&
                             (region == mem_ctrl_pkg::region_t'(r));
        end
    end

    assign load_o        = (state == mem_ctrl_pkg::SEQ_FINISH) &&
                           (op == mem_ctrl_pkg::OP_LD_WEIGHT);
    assign array_start_o = (state == mem_ctrl_pkg::SEQ_FINISH) &&
                           (op == mem_ctrl_pkg::OP_LD_INPUT);

    assign status_o.design_busy = busy;
    assign status_o.busy_err    = in_err && err_busy;
    assign status_o.occu_err_w  = in_err && !err_busy && (region == mem_ctrl_pkg::REG_WEIGHT);
    assign status_o.occu_err_i  = in_err && !err_busy && (region == mem_ctrl_pkg::REG_INPUT);
    assign status_o.occu_err_o  = in_err && !err_busy && (region == mem_ctrl_pkg::REG_OUTPUT);

endmodule

// ==== design/region_ptr.sv ====
`include "mem_ctrl_settings.svh"

module region_ptr #(
    parameter int BASE = 0
) (
    input  logic                        clk,
    input  logic                        n_rst,
    input  mem_ctrl_pkg::region_step_t  step_i,
    input  logic                        half_i,
    output mem_ctrl_pkg::region_flags_t flags_o,
    output mem_ctrl_pkg::region_addr_t  addr_o
);

    localparam int PTR_W = $clog2(`REGION_ENTRIES);
    localparam int AW    = `ADDR_W;

    // msb is the wrap flag, the rest counts entries
    logic [PTR_W:0] wr_q;
    logic [PTR_W:0] rd_q;

    function automatic logic [PTR_W:0] advance(input logic [PTR_W:0] cur);
        if (cur[PTR_W-1:0] == PTR_W'(`REGION_ENTRIES - 1))
            return {~cur[PTR_W], {PTR_W{1'b0}}};
        else
            return cur + 1'b1;
    endfunction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_q <= '0;
            rd_q <= '0;
        end else begin
            if (step_i.push)
                wr_q <= advance(wr_q);
            if (step_i.pop)
                rd_q <= advance(rd_q);
        end
    end

    // same position, the wrap flags tell full from empty
    assign flags_o.empty = (wr_q == rd_q);
    assign flags_o.full  = (wr_q[PTR_W-1:0] == rd_q[PTR_W-1:0]) &&
                           (wr_q[PTR_W] != rd_q[PTR_W]);

    // two words per entry
    assign addr_o.wr_addr = AW'(BASE) + AW'({wr_q[PTR_W-1:0], half_i});
    assign addr_o.rd_addr = AW'(BASE) + AW'({rd_q[PTR_W-1:0], half_i});

endmodule

// ==== design/sram_port.sv ====
`include "mem_ctrl_settings.svh"

module sram_port (
    input  logic                             clk,
    input  logic                             n_rst,
    input  mem_ctrl_pkg::sram_access_t       access_i,
    input  mem_ctrl_pkg::region_addr_t [2:0] addr_i,
    input  logic [`DATA_W-1:0]               weight_data_i,
    input  logic [`DATA_W-1:0]               input_data_i,
    input  logic [`DATA_W-1:0]               activations_i,
    input  logic [`WORD_W-1:0]               sram_read_data_i,
    output mem_ctrl_pkg::sram_req_t          sram_req_o,
    output logic [`DATA_W-1:0]               array_data_o,
    output logic [`DATA_W-1:0]               output_data_o
);

    logic [`DATA_W-1:0] wr_entry;

    // host entry feeding the current write
    always_comb begin
        case (access_i.region)
            mem_ctrl_pkg::REG_WEIGHT: wr_entry = weight_data_i;
            mem_ctrl_pkg::REG_INPUT:  wr_entry = input_data_i;
            default:                  wr_entry = activations_i;
        endcase
    end

    assign sram_req_o.read_en    = access_i.read_en;
    assign sram_req_o.write_en   = access_i.write_en;
    assign sram_req_o.addr       = access_i.write_en ? addr_i[access_i.region].wr_addr
                                                     : addr_i[access_i.region].rd_addr;
    assign sram_req_o.write_data = access_i.hi ? wr_entry[`DATA_W-1:`WORD_W]
                                               : wr_entry[`WORD_W-1:0];

    // weight and input reads go to the array, output reads to the host
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            array_data_o  <= '0;
            output_data_o <= '0;
        end else if (access_i.capture) begin
            if (access_i.region == mem_ctrl_pkg::REG_OUTPUT) begin
                if (access_i.hi)
                    output_data_o[`DATA_W-1:`WORD_W] <= sram_read_data_i;
                else
                    output_data_o[`WORD_W-1:0] <= sram_read_data_i;
            end else begin
                if (access_i.hi)
                    array_data_o[`DATA_W-1:`WORD_W] <= sram_read_data_i;
                else
                    array_data_o[`WORD_W-1:0] <= sram_read_data_i;
            end
        end
    end

endmodule

// ==== design/mem_ctrl_top.sv ====
`include "mem_ctrl_settings.svh"

module mem_ctrl_top (
    input  logic                       clk,
    input  logic                       n_rst,
    input  mem_ctrl_pkg::host_cmd_t    cmd_i,
    input  logic                       activations_valid_i,
    input  logic [`DATA_W-1:0]         weight_data_i,
    input  logic [`DATA_W-1:0]         input_data_i,
    input  logic [`DATA_W-1:0]         activations_i,
    input  logic                       array_busy_i,
    input  logic [`WORD_W-1:0]         sram_read_data_i,
    input  mem_ctrl_pkg::sram_state_t  sram_state_i,
    output mem_ctrl_pkg::ctrl_status_t status_o,
    output logic                       load_o,
    output logic                       array_start_o,
    output logic [`DATA_W-1:0]         array_data_o,
    output logic [`DATA_W-1:0]         output_data_o,
    output mem_ctrl_pkg::sram_req_t    sram_req_o
);

    mem_ctrl_pkg::region_step_t  [2:0] step;
    mem_ctrl_pkg::region_flags_t [2:0] flags;
    mem_ctrl_pkg::region_addr_t  [2:0] addr;
    mem_ctrl_pkg::sram_access_t        access;

    cmd_sequencer cmd_sequencer_i (
        .clk                 (clk),
        .n_rst               (n_rst),
        .cmd_i               (cmd_i),
        .activations_valid_i (activations_valid_i),
        .array_busy_i        (array_busy_i),
        .sram_state_i        (sram_state_i),
        .flags_i             (flags),
        .step_o              (step),
        .access_o            (access),
        .status_o            (status_o),
        .load_o              (load_o),
        .array_start_o       (array_start_o)
    );

    // one pointer pair per region
    for (genvar g = 0; g <= int'(mem_ctrl_pkg::REG_OUTPUT); g++) begin : g_region
        localparam int BASE =
            (mem_ctrl_pkg::region_t'(g) == mem_ctrl_pkg::REG_WEIGHT) ? `WEIGHT_BASE :
            (mem_ctrl_pkg::region_t'(g) == mem_ctrl_pkg::REG_INPUT)  ? `INPUT_BASE  :
                                                                      `OUTPUT_BASE;

        region_ptr #(
            .BASE (BASE)
        ) region_ptr_i (
            .clk     (clk),
            .n_rst   (n_rst),
            .step_i  (step[g]),
            .half_i  (access.hi),
            .flags_o (flags[g]),
            .addr_o  (addr[g])
        );
    end

    sram_port sram_port_i (
        .clk              (clk),
        .n_rst            (n_rst),
        .access_i         (access),
        .addr_i           (addr),
        .weight_data_i    (weight_data_i),
        .input_data_i     (input_data_i),
        .activations_i    (activations_i),
        .sram_read_data_i (sram_read_data_i),
        .sram_req_o       (sram_req_o),
        .array_data_o     (array_data_o),
        .output_data_o    (output_data_o)
    );

endmodule

// ==== tests/sram_model.sv ====
`include "mem_ctrl_settings.svh"

module sram_model (
    input  logic                      clk,
    input  logic                      n_rst,
    input  mem_ctrl_pkg::sram_req_t   req_i,
    output mem_ctrl_pkg::sram_state_t state_o,
    output logic [`WORD_W-1:0]        read_data_o
);

    logic [`WORD_W-1:0] mem [2**`ADDR_W];

    // idle, busy for one cycle, done with the data, then idle again
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state_o     <= mem_ctrl_pkg::SRAM_IDLE;
            read_data_o <= '0;
        end else begin
            case (state_o)
                mem_ctrl_pkg::SRAM_IDLE: begin
                    if (req_i.read_en || req_i.write_en)
                        state_o <= mem_ctrl_pkg::SRAM_BUSY;
                end
                mem_ctrl_pkg::SRAM_BUSY: begin
                    if (req_i.write_en)
                        mem[req_i.addr] <= req_i.write_data;
                    else
                        read_data_o <= mem[req_i.addr];
                    state_o <= mem_ctrl_pkg::SRAM_DONE;
                end
                default: state_o <= mem_ctrl_pkg::SRAM_IDLE;
            endcase
        end
    end

endmodule

// ==== tests/mem_ctrl_assert.sv ====
module mem_ctrl_assert (
    input logic                       clk,
    input logic                       n_rst,
    input mem_ctrl_pkg::ctrl_status_t status_i,
    input mem_ctrl_pkg::sram_req_t    sram_req_i
);

    int fail_count = 0;

    property two_cycle_flag(logic flag);
        @(posedge clk) disable iff (!n_rst)
        $rose(flag) |=> flag ##1 !flag;
    endproperty

    rw_exclusive: assert property (@(posedge clk) disable iff (!n_rst)
        !(sram_req_i.read_en && sram_req_i.write_en))
    else begin
        fail_count++;
        $error("sram read and write enables high together");
    end

    busy_err_len: assert property (two_cycle_flag(status_i.busy_err))
    else begin
        fail_count++;
        $error("busy_err not high for exactly two cycles");
    end

    occu_w_len: assert property (two_cycle_flag(status_i.occu_err_w))
    else begin
        fail_count++;
        $error("occu_err_w not high for exactly two cycles");
    end

    occu_i_len: assert property (two_cycle_flag(status_i.occu_err_i))
    else begin
        fail_count++;
        $error("occu_err_i not high for exactly two cycles");
    end

    occu_o_len: assert property (two_cycle_flag(status_i.occu_err_o))
    else begin
        fail_count++;
        $error("occu_err_o not high for exactly two cycles");
    end

    one_error: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0({status_i.busy_err, status_i.occu_err_w,
                  status_i.occu_err_i, status_i.occu_err_o}))
    else begin
        fail_count++;
        $error("more than one error flag high");
    end

    // three regions of 336 words
    addr_range: assert property (@(posedge clk) disable iff (!n_rst)
        (sram_req_i.read_en || sram_req_i.write_en) |-> sram_req_i.addr <= 1007)
    else begin
        fail_count++;
        $error("sram address outside the regions");
    end

endmodule

bind mem_ctrl_top mem_ctrl_assert mem_ctrl_assert_i (
    .clk        (clk),
    .n_rst      (n_rst),
    .status_i   (status_o),
    .sram_req_i (sram_req_o)
);

// ==== tests/mem_ctrl_tb.sv ====
`include "mem_ctrl_settings.svh"

module mem_ctrl_tb;

    // sram entry accesses over all tests, each about ten cycles
    localparam int ENTRY_OPS   = 177;
    localparam int CYCLE_LIMIT = 30 * ENTRY_OPS + 100;

    localparam mem_ctrl_pkg::host_cmd_t CMD_NONE      = 5'b00000;
    localparam mem_ctrl_pkg::host_cmd_t CMD_WR_WEIGHT = 5'b10000;
    localparam mem_ctrl_pkg::host_cmd_t CMD_WR_INPUT  = 5'b01000;
    localparam mem_ctrl_pkg::host_cmd_t CMD_LD_WEIGHT = 5'b00100;
    localparam mem_ctrl_pkg::host_cmd_t CMD_START     = 5'b00010;
    localparam mem_ctrl_pkg::host_cmd_t CMD_RD_OUTPUT = 5'b00001;

    logic                       clk;
    logic                       n_rst;
    mem_ctrl_pkg::host_cmd_t    cmd;
    logic                       act_valid;
    logic [`DATA_W-1:0]         weight_data;
    logic [`DATA_W-1:0]         input_data;
    logic [`DATA_W-1:0]         activations;
    logic                       array_busy;
    logic [`WORD_W-1:0]         sram_rdata;
    mem_ctrl_pkg::sram_state_t  sram_state;
    mem_ctrl_pkg::ctrl_status_t status;
    logic                       load;
    logic                       array_start;
    logic [`DATA_W-1:0]         array_data;
    logic [`DATA_W-1:0]         output_data;
    mem_ctrl_pkg::sram_req_t    sram_req;

    logic [31:0] lfsr = 32'h122a_fa03;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    // what the monitor saw during one operation
    mem_ctrl_pkg::ctrl_status_t status_seen;
    int                         err_cycles;
    int                         en_cycles;
    int                         load_cnt;
    int                         start_cnt;
    logic [`ADDR_W-1:0]         first_addr;
    logic [`DATA_W-1:0]         pulse_data;

    mem_ctrl_top mem_ctrl_top_i (
        .clk                 (clk),
        .n_rst               (n_rst),
        .cmd_i               (cmd),
        .activations_valid_i (act_valid),
        .weight_data_i       (weight_data),
        .input_data_i        (input_data),
        .activations_i       (activations),
        .array_busy_i        (array_busy),
        .sram_read_data_i    (sram_rdata),
        .sram_state_i        (sram_state),
        .status_o            (status),
        .load_o              (load),
        .array_start_o       (array_start),
        .array_data_o        (array_data),
        .output_data_o       (output_data),
        .sram_req_o          (sram_req)
    );

    sram_model sram_model_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .req_i       (sram_req),
        .state_o     (sram_state),
        .read_data_o (sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: no result after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // sampled mid-cycle, away from the edges
    always @(negedge clk) begin
        if (n_rst) begin
            status_seen = status_seen | status;
            if (status.busy_err || status.occu_err_w || status.occu_err_i || status.occu_err_o)
                err_cycles++;
            if (sram_req.read_en || sram_req.write_en) begin
                if (en_cycles == 0)
                    first_addr = sram_req.addr;
                en_cycles++;
            end
            if (load)
                load_cnt++;
            if (array_start)
                start_cnt++;
            if (load || array_start)
                pulse_data = array_data;
        end
    end

    function automatic logic [`DATA_W-1:0] rand_entry();
        logic [`DATA_W-1:0] val;
        logic               fb;
        val = '0;
        for (int i = 0; i < `DATA_W; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[`DATA_W-2:0], fb};
        end
        return val;
    endfunction

    function automatic mem_ctrl_pkg::ctrl_status_t err_status(input logic b, input logic w,
                                                              input logic i, input logic o);
        return {1'b1, b, w, i, o};
    endfunction

    task automatic check_status(input string name, input mem_ctrl_pkg::ctrl_status_t got,
                                input mem_ctrl_pkg::ctrl_status_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`ADDR_W-1:0] got,
                              input logic [`ADDR_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("%s happened %0d times instead of %0d", what, got, exp);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_monitor();
        status_seen = '0;
        err_cycles  = 0;
        en_cycles   = 0;
        load_cnt    = 0;
        start_cnt   = 0;
    endtask

    // returns once the sequencer is back in idle
    task automatic wait_idle();
        while (status.design_busy || status.busy_err || status.occu_err_w ||
               status.occu_err_i || status.occu_err_o)
            tick();
    endtask

    task automatic run_op(input mem_ctrl_pkg::host_cmd_t c, input logic act);
        clear_monitor();
        cmd       = c;
        act_valid = act;
        tick();
        cmd       = CMD_NONE;
        act_valid = 1'b0;
        wait_idle();
    endtask

    task automatic check_error_op(input string what, input mem_ctrl_pkg::ctrl_status_t exp);
        check_status({what, " status_o"}, status_seen, exp);
        check_count({what, " error flag cycle"}, err_cycles, 2);
        check_count({what, " sram enable cycle"}, en_cycles, 0);
    endtask

    task automatic report_test(input string name, input int errs_in);
        tests_run++;
        if (errors == errs_in) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - errs_in);
        end
    endtask

    task automatic output_round_trip();
        logic [`DATA_W-1:0] entry [2];
        int                 errs_in;
        errs_in = errors;
        for (int k = 0; k < 2; k++) begin
            entry[k]    = rand_entry();
            activations = entry[k];
            run_op(CMD_NONE, 1'b1);
            check_addr("sram_req_o.addr", first_addr, `OUTPUT_BASE + 2 * k);
        end
        for (int k = 0; k < 2; k++) begin
            run_op(CMD_RD_OUTPUT, 1'b0);
            check_addr("sram_req_o.addr", first_addr, `OUTPUT_BASE + 2 * k);
            check_data("output_data_o", output_data, entry[k]);
        end
        // stays quiet with no command pending
        tick();
        check_status("status_o", status, '0);
        report_test("output round trip", errs_in);
    endtask

    task automatic weight_path();
        int errs_in;
        errs_in     = errors;
        weight_data = rand_entry();
        run_op(CMD_WR_WEIGHT, 1'b0);
        check_addr("sram_req_o.addr", first_addr, `WEIGHT_BASE);
        run_op(CMD_LD_WEIGHT, 1'b0);
        check_count("load_o pulse", load_cnt, 1);
        check_count("array_start_o pulse", start_cnt, 0);
        check_data("array_data_o", pulse_data, weight_data);
        report_test("weight path", errs_in);
    endtask

    task automatic input_path();
        int errs_in;
        errs_in    = errors;
        input_data = rand_entry();
        run_op(CMD_WR_INPUT, 1'b0);
        check_addr("sram_req_o.addr", first_addr, `INPUT_BASE);
        run_op(CMD_START, 1'b0);
        check_count("array_start_o pulse", start_cnt, 1);
        check_count("load_o pulse", load_cnt, 0);
        check_data("array_data_o", pulse_data, input_data);
        report_test("input path", errs_in);
    endtask

    task automatic empty_errors();
        int errs_in;
        errs_in = errors;
        run_op(CMD_LD_WEIGHT, 1'b0);
        check_error_op("load_weight", err_status(1'b0, 1'b1, 1'b0, 1'b0));
        run_op(CMD_START, 1'b0);
        check_error_op("start_inference", err_status(1'b0, 1'b0, 1'b1, 1'b0));
        run_op(CMD_RD_OUTPUT, 1'b0);
        check_error_op("output_read", err_status(1'b0, 1'b0, 1'b0, 1'b1));
        report_test("empty errors", errs_in);
    endtask

    task automatic busy_error();
        int errs_in;
        errs_in     = errors;
        weight_data = rand_entry();
        clear_monitor();
        cmd = CMD_WR_WEIGHT;
        tick();
        // a second command while the write is under way
        cmd = CMD_WR_INPUT;
        tick();
        cmd = CMD_NONE;
        wait_idle();
        check_status("status_o", status_seen, err_status(1'b1, 1'b0, 1'b0, 1'b0));
        check_count("busy error flag cycle", err_cycles, 2);
        run_op(CMD_LD_WEIGHT, 1'b0);
        check_error_op("load_weight", err_status(1'b0, 1'b1, 1'b0, 1'b0));
        report_test("busy error", errs_in);
    endtask

    task automatic full_error();
        logic [`DATA_W-1:0] first;
        int                 bad_writes;
        int                 errs_in;
        errs_in    = errors;
        bad_writes = 0;
        for (int k = 0; k < `REGION_ENTRIES; k++) begin
            input_data = rand_entry();
            if (k == 0)
                first = input_data;
            run_op(CMD_WR_INPUT, 1'b0);
            if (err_cycles != 0)
                bad_writes++;
        end
        check_count("error during a fill write", bad_writes, 0);
        run_op(CMD_WR_INPUT, 1'b0);
        check_error_op("write_input", err_status(1'b0, 1'b0, 1'b1, 1'b0));
        run_op(CMD_START, 1'b0);
        check_count("array_start_o pulse", start_cnt, 1);
        check_data("array_data_o", pulse_data, first);
        report_test("full error", errs_in);
    endtask

    initial begin
        n_rst       = 1'b0;
        cmd         = CMD_NONE;
        act_valid   = 1'b0;
        weight_data = '0;
        input_data  = '0;
        activations = '0;
        array_busy  = 1'b0;
        clear_monitor();
        repeat (4) @(posedge clk);
        #2;
        n_rst = 1'b1;
        tick();

        output_round_trip();
        weight_path();
        input_path();
        empty_errors();
        busy_error();
        full_error();

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, mem_ctrl_top_i.mem_ctrl_assert_i.fail_count);
        if (errors == 0 && mem_ctrl_top_i.mem_ctrl_assert_i.fail_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
design/mem_ctrl_pkg.sv
design/cmd_sequencer.sv
design/region_ptr.sv
design/sram_port.sv
design/mem_ctrl_top.sv
tests/sram_model.sv
tests/mem_ctrl_assert.sv
tests/mem_ctrl_tb.sv
